/* src/vi_pkg.sv */
// Core shared definitions
`default_nettype none

package vi_pkg;

	localparam int XLEN = 32;
	localparam int ILEN = 32;
	localparam int NREGS = 32;
	localparam int RADDR_W = 5;
	localparam int N_EXE = 5;
	localparam int MUL_STAGES = 4;

	// Instruction fields
	localparam int OPC_W = 4;
	localparam int OPC_LSB = 28;
	localparam int RD_LSB = 23;
	localparam int RA_LSB = 18;
	localparam int RB_LSB = 13;
	localparam int IMM_W = 16;

	typedef enum logic [OPC_W-1:0] {
		OP_NOP = 4'h0,
		OP_ADD = 4'h1,
		OP_SUB = 4'h2,
		OP_AND = 4'h3,
		OP_OR  = 4'h4,
		OP_XOR = 4'h5,
		OP_SLL = 4'h6,
		OP_SRL = 4'h7,
		OP_LI  = 4'h8,
		OP_MUL = 4'h9
	} opcode_e;

	typedef struct packed {
		logic               valid;
		opcode_e            opcode;
		logic [RADDR_W-1:0] rd;
		logic               we;
		logic [XLEN-1:0]    a;
		logic [XLEN-1:0]    b;
	} dec_op_t;

	typedef struct packed {
		logic               we;
		logic [RADDR_W-1:0] rd;
		logic [XLEN-1:0]    data;
		logic               data_ok;
	} stage_fwd_t;

endpackage

`default_nettype wire

/* src/vi_fwd_if.sv */
// Forwarding bus
`timescale 1ns/1ps
`default_nettype none

interface vi_fwd_if;

	// Index 0 is E1, index N_EXE-1 is E5
	vi_pkg::stage_fwd_t [vi_pkg::N_EXE-1:0] exe;
	vi_pkg::stage_fwd_t                     wb;

	modport src (
		output exe,
		output wb
	);

	modport dst (
		input exe,
		input wb
	);

endinterface

`default_nettype wire

/* src/vi_int_registers.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module vi_int_registers (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire  [vi_pkg::RADDR_W-1:0]   read_addr_a_i,
	input  wire  [vi_pkg::RADDR_W-1:0]   read_addr_b_i,
	output logic [vi_pkg::XLEN-1:0]      read_data_a_o,
	output logic [vi_pkg::XLEN-1:0]      read_data_b_o,
	input  wire                          write_en_i,
	input  wire  [vi_pkg::RADDR_W-1:0]   write_addr_i,
	input  wire  [vi_pkg::XLEN-1:0]      write_data_i
);

	logic [vi_pkg::XLEN-1:0] regs [vi_pkg::NREGS];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < vi_pkg::NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en_i && write_addr_i != '0) begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	// Same-cycle write is visible to the reader
	assign read_data_a_o = (read_addr_a_i == '0) ? '0 :
		(write_en_i && write_addr_i == read_addr_a_i) ? write_data_i : regs[read_addr_a_i];
	assign read_data_b_o = (read_addr_b_i == '0) ? '0 :
		(write_en_i && write_addr_i == read_addr_b_i) ? write_data_i : regs[read_addr_b_i];

endmodule

`default_nettype wire

/* src/vi_decoder.sv */
// Decode stage
`timescale 1ns/1ps
`default_nettype none

module vi_decoder (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire                          instr_valid_i,
	input  wire  [vi_pkg::ILEN-1:0]      instr_i,
	output logic                         instr_ready_o,
	output logic [vi_pkg::RADDR_W-1:0]   read_addr_a_o,
	output logic [vi_pkg::RADDR_W-1:0]   read_addr_b_o,
	output logic                         src_used_a_o,
	output logic                         src_used_b_o,
	input  wire  [vi_pkg::XLEN-1:0]      reg_data_a_i,
	input  wire  [vi_pkg::XLEN-1:0]      reg_data_b_i,
	input  wire                          bypass_a_en_i,
	input  wire                          bypass_b_en_i,
	input  wire  [vi_pkg::XLEN-1:0]      bypass_data_a_i,
	input  wire  [vi_pkg::XLEN-1:0]      bypass_data_b_i,
	input  wire                          stall_i,
	output vi_pkg::dec_op_t              op_o
);

	logic [vi_pkg::ILEN-1:0]    instr_q;
	logic                       full_q;
	logic                       accept;
	logic                       writes;
	vi_pkg::opcode_e            opc;
	logic [vi_pkg::RADDR_W-1:0] rd;
	logic [vi_pkg::XLEN-1:0]    imm;

	assign instr_ready_o = !full_q || !stall_i;
	assign accept = instr_valid_i && instr_ready_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			full_q <= 1'b0;
		end else if (accept) begin
			full_q <= 1'b1;
		end else if (!stall_i) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			instr_q <= instr_i;
		end
	end

	assign opc = vi_pkg::opcode_e'(instr_q[vi_pkg::OPC_LSB +: vi_pkg::OPC_W]);
	assign rd = instr_q[vi_pkg::RD_LSB +: vi_pkg::RADDR_W];
	assign read_addr_a_o = instr_q[vi_pkg::RA_LSB +: vi_pkg::RADDR_W];
	assign read_addr_b_o = instr_q[vi_pkg::RB_LSB +: vi_pkg::RADDR_W];
	assign imm = {{(vi_pkg::XLEN-vi_pkg::IMM_W){1'b0}}, instr_q[vi_pkg::IMM_W-1:0]};

	// Which sources are read, and whether rd is written
	always_comb begin
		src_used_a_o = 1'b0;
		src_used_b_o = 1'b0;
		writes = 1'b0;
		case (opc)
			vi_pkg::OP_ADD, vi_pkg::OP_SUB, vi_pkg::OP_AND, vi_pkg::OP_OR,
			vi_pkg::OP_XOR, vi_pkg::OP_SLL, vi_pkg::OP_SRL, vi_pkg::OP_MUL: begin
				src_used_a_o = full_q;
				src_used_b_o = full_q;
				writes = 1'b1;
			end
			vi_pkg::OP_LI: writes = 1'b1;
			default: writes = 1'b0;
		endcase
	end

	always_comb begin
		op_o.valid = full_q && !stall_i;
		op_o.opcode = opc;
		op_o.rd = rd;
		op_o.we = writes && (rd != '0);
		op_o.a = bypass_a_en_i ? bypass_data_a_i : reg_data_a_i;
		if (opc == vi_pkg::OP_LI) begin
			op_o.b = imm;
		end else begin
			op_o.b = bypass_b_en_i ? bypass_data_b_i : reg_data_b_i;
		end
	end

endmodule

`default_nettype wire

/* src/vi_bypass_ctrl.sv */
// Operand bypass and hazard stall
`timescale 1ns/1ps
`default_nettype none

module vi_bypass_ctrl (
	input  wire  [vi_pkg::RADDR_W-1:0]   read_addr_a_i,
	input  wire  [vi_pkg::RADDR_W-1:0]   read_addr_b_i,
	input  wire                          src_used_a_i,
	input  wire                          src_used_b_i,
	vi_fwd_if.dst                        fwd,
	output logic                         bypass_a_en_o,
	output logic                         bypass_b_en_o,
	output logic [vi_pkg::XLEN-1:0]      bypass_data_a_o,
	output logic [vi_pkg::XLEN-1:0]      bypass_data_b_o,
	output logic                         stall_o
);

	vi_pkg::stage_fwd_t hit_a;
	vi_pkg::stage_fwd_t hit_b;

	// The we bit of the returned entry marks a match
	function automatic vi_pkg::stage_fwd_t youngest_match(
		input logic [vi_pkg::RADDR_W-1:0]             addr,
		input logic                                   used,
		input vi_pkg::stage_fwd_t [vi_pkg::N_EXE-1:0] exe,
		input vi_pkg::stage_fwd_t                     wb
	);
		vi_pkg::stage_fwd_t hit;
		hit = '0;
		if (used && addr != '0) begin
			// E1 holds the youngest op
			for (int s = 0; s < vi_pkg::N_EXE; s++) begin
				if (!hit.we && exe[s].we && exe[s].rd == addr) begin
					hit = exe[s];
				end
			end
			if (!hit.we && wb.we && wb.rd == addr) begin
				hit = wb;
			end
		end
		return hit;
	endfunction

	assign hit_a = youngest_match(read_addr_a_i, src_used_a_i, fwd.exe, fwd.wb);
	assign hit_b = youngest_match(read_addr_b_i, src_used_b_i, fwd.exe, fwd.wb);

	assign bypass_a_en_o = hit_a.we;
	assign bypass_b_en_o = hit_b.we;
	assign bypass_data_a_o = hit_a.data;
	assign bypass_data_b_o = hit_b.data;

	// Only an unfinished product holds decode
	assign stall_o = (hit_a.we && !hit_a.data_ok) || (hit_b.we && !hit_b.data_ok);

endmodule

`default_nettype wire

/* src/vi_execute.sv */
// Execute pipeline
`timescale 1ns/1ps
`default_nettype none

module vi_execute (
	input  wire                 clk_i,
	input  wire                 rst_i,
	input  wire vi_pkg::dec_op_t op_i,
	vi_fwd_if.src               fwd,
	output vi_pkg::stage_fwd_t  res_o
);

	logic [vi_pkg::N_EXE-1:0]   st_we;
	logic [vi_pkg::N_EXE-1:0]   st_mul;
	logic [vi_pkg::RADDR_W-1:0] st_rd [vi_pkg::N_EXE];
	logic [vi_pkg::XLEN-1:0]    st_a [vi_pkg::N_EXE];
	logic [vi_pkg::XLEN-1:0]    st_b [vi_pkg::N_EXE];
	logic [vi_pkg::XLEN-1:0]    st_acc [vi_pkg::N_EXE];
	logic [vi_pkg::XLEN-1:0]    acc_next [vi_pkg::N_EXE];

	function automatic logic [vi_pkg::XLEN-1:0] alu(
		input vi_pkg::opcode_e          opc,
		input logic [vi_pkg::XLEN-1:0]  a,
		input logic [vi_pkg::XLEN-1:0]  b
	);
		case (opc)
			vi_pkg::OP_ADD: return a + b;
			vi_pkg::OP_SUB: return a - b;
			vi_pkg::OP_AND: return a & b;
			vi_pkg::OP_OR:  return a | b;
			vi_pkg::OP_XOR: return a ^ b;
			vi_pkg::OP_SLL: return a << b[4:0];
			vi_pkg::OP_SRL: return a >> b[4:0];
			vi_pkg::OP_LI:  return b;
			// First partial product of the multiply
			vi_pkg::OP_MUL: return a * b[7:0];
			default:        return '0;
		endcase
	endfunction

	// E2..E4 add one more byte of b to the product
	always_comb begin
		acc_next[0] = alu(op_i.opcode, op_i.a, op_i.b);
		for (int s = 1; s < vi_pkg::N_EXE; s++) begin
			acc_next[s] = st_acc[s-1];
			if (st_mul[s-1] && s < vi_pkg::MUL_STAGES) begin
				acc_next[s] = st_acc[s-1] +
					((st_a[s-1] * st_b[s-1][8*s +: 8]) << (8*s));
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			st_we <= '0;
			st_mul <= '0;
		end else begin
			st_we <= {st_we[vi_pkg::N_EXE-2:0], op_i.valid && op_i.we};
			st_mul <= {st_mul[vi_pkg::N_EXE-2:0],
				op_i.valid && (op_i.opcode == vi_pkg::OP_MUL)};
		end
	end

	always_ff @(posedge clk_i) begin
		st_rd[0] <= op_i.rd;
		st_a[0] <= op_i.a;
		st_b[0] <= op_i.b;
		st_acc[0] <= acc_next[0];
		for (int s = 1; s < vi_pkg::N_EXE; s++) begin
			st_rd[s] <= st_rd[s-1];
			st_a[s] <= st_a[s-1];
			st_b[s] <= st_b[s-1];
			st_acc[s] <= acc_next[s];
		end
	end

	// Products are complete once the op reaches E5
	always_comb begin
		for (int s = 0; s < vi_pkg::N_EXE; s++) begin
			fwd.exe[s].we = st_we[s];
			fwd.exe[s].rd = st_rd[s];
			fwd.exe[s].data = st_acc[s];
			fwd.exe[s].data_ok = !st_mul[s] || (s >= vi_pkg::MUL_STAGES);
		end
	end

	assign res_o.we = st_we[vi_pkg::N_EXE-1];
	assign res_o.rd = st_rd[vi_pkg::N_EXE-1];
	assign res_o.data = st_acc[vi_pkg::N_EXE-1];
	assign res_o.data_ok = 1'b1;

endmodule

`default_nettype wire

/* src/vi_writeback.sv */
// Result stage
`timescale 1ns/1ps
`default_nettype none

module vi_writeback (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire vi_pkg::stage_fwd_t    res_i,
	vi_fwd_if.src                      fwd,
	output logic                       reg_we_o,
	output logic [vi_pkg::RADDR_W-1:0] reg_addr_o,
	output logic [vi_pkg::XLEN-1:0]    reg_data_o,
	output logic                       wb_valid_o,
	output logic [vi_pkg::RADDR_W-1:0] wb_addr_o,
	output logic [vi_pkg::XLEN-1:0]    wb_data_o
);

	vi_pkg::stage_fwd_t wb_q;

	always_ff @(posedge clk_i) begin
		wb_q <= res_i;
		if (rst_i) begin
			wb_q.we <= 1'b0;
		end
	end

	// Oldest bypass source, covers the cycle before the register file write
	assign fwd.wb = wb_q;

	assign reg_we_o = wb_q.we;
	assign reg_addr_o = wb_q.rd;
	assign reg_data_o = wb_q.data;
	assign wb_valid_o = wb_q.we;
	assign wb_addr_o = wb_q.rd;
	assign wb_data_o = wb_q.data;

endmodule

`default_nettype wire

/* src/vi_core.sv */
// Pipeline core top level
`timescale 1ns/1ps
`default_nettype none

module vi_core (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire                        instr_valid_i,
	input  wire  [vi_pkg::ILEN-1:0]    instr_i,
	output logic                       instr_ready_o,
	output logic                       wb_valid_o,
	output logic [vi_pkg::RADDR_W-1:0] wb_addr_o,
	output logic [vi_pkg::XLEN-1:0]    wb_data_o
);

	logic [vi_pkg::RADDR_W-1:0] dec_read_addr_a;
	logic [vi_pkg::RADDR_W-1:0] dec_read_addr_b;
	logic                       dec_src_used_a;
	logic                       dec_src_used_b;
	logic [vi_pkg::XLEN-1:0]    reg_read_data_a;
	logic [vi_pkg::XLEN-1:0]    reg_read_data_b;
	logic                       bypass_a_en;
	logic                       bypass_b_en;
	logic [vi_pkg::XLEN-1:0]    bypass_data_a;
	logic [vi_pkg::XLEN-1:0]    bypass_data_b;
	logic                       dec_stall;
	vi_pkg::dec_op_t            dec_op;
	vi_pkg::stage_fwd_t         exe_res;
	logic                       reg_we;
	logic [vi_pkg::RADDR_W-1:0] reg_addr;
	logic [vi_pkg::XLEN-1:0]    reg_data;

	vi_fwd_if fwd_if ();

	vi_decoder decoder (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.instr_ready_o   (instr_ready_o),
		.read_addr_a_o   (dec_read_addr_a),
		.read_addr_b_o   (dec_read_addr_b),
		.src_used_a_o    (dec_src_used_a),
		.src_used_b_o    (dec_src_used_b),
		.reg_data_a_i    (reg_read_data_a),
		.reg_data_b_i    (reg_read_data_b),
		.bypass_a_en_i   (bypass_a_en),
		.bypass_b_en_i   (bypass_b_en),
		.bypass_data_a_i (bypass_data_a),
		.bypass_data_b_i (bypass_data_b),
		.stall_i         (dec_stall),
		.op_o            (dec_op)
	);

	vi_bypass_ctrl bypass_ctrl (
		.read_addr_a_i   (dec_read_addr_a),
		.read_addr_b_i   (dec_read_addr_b),
		.src_used_a_i    (dec_src_used_a),
		.src_used_b_i    (dec_src_used_b),
		.fwd             (fwd_if.dst),
		.bypass_a_en_o   (bypass_a_en),
		.bypass_b_en_o   (bypass_b_en),
		.bypass_data_a_o (bypass_data_a),
		.bypass_data_b_o (bypass_data_b),
		.stall_o         (dec_stall)
	);

	vi_int_registers int_registers (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.read_addr_a_i (dec_read_addr_a),
		.read_addr_b_i (dec_read_addr_b),
		.read_data_a_o (reg_read_data_a),
		.read_data_b_o (reg_read_data_b),
		.write_en_i    (reg_we),
		.write_addr_i  (reg_addr),
		.write_data_i  (reg_data)
	);

	vi_execute execute (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.op_i  (dec_op),
		.fwd   (fwd_if.src),
		.res_o (exe_res)
	);

	vi_writeback writeback (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.res_i      (exe_res),
		.fwd        (fwd_if.src),
		.reg_we_o   (reg_we),
		.reg_addr_o (reg_addr),
		.reg_data_o (reg_data),
		.wb_valid_o (wb_valid_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

`default_nettype wire

/* dv/vi_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module vi_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	localparam int HALF_PERIOD_NS = 50;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
	end

	// Synchronous reset held over the first rising edges
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* dv/vi_core_assertions.sv */
// Core port assertions
`timescale 1ns/1ps
`default_nettype none

module vi_core_assertions (
	input wire                       clk_i,
	input wire                       rst_i,
	input wire                       instr_ready_i,
	input wire                       wb_valid_i,
	input wire [vi_pkg::RADDR_W-1:0] wb_addr_i
);

	wb_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !wb_valid_i)
		else $error("wb_valid_o high in the cycle after reset");

	// r0 is never reported as written
	wb_addr_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_valid_i |-> wb_addr_i != '0)
		else $error("wb_valid_o with wb_addr_o equal to zero");

	// A MUL hazard stalls for at most four cycles
	ready_low_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
		!(!instr_ready_i && !$past(instr_ready_i, 1) && !$past(instr_ready_i, 2) &&
		!$past(instr_ready_i, 3) && !$past(instr_ready_i, 4)))
		else $error("instr_ready_o low for more than four cycles");

	wb_valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
		!$isunknown(wb_valid_i))
		else $error("wb_valid_o is unknown");

endmodule

bind vi_core vi_core_assertions assertions (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.instr_ready_i (instr_ready_o),
	.wb_valid_i    (wb_valid_o),
	.wb_addr_i     (wb_addr_o)
);

`default_nettype wire

/* dv/vi_core_tb.sv */
// Core testbench
`timescale 1ns/1ps
`default_nettype none

module vi_core_tb;

	localparam int N_INSTR = 400;
	localparam int CYCLES_PER_INSTR = 12;
	localparam int RESET_CYCLES = 4;
	localparam int DRAIN_CYCLES = 20;
	localparam int SETTLE_CYCLES = 4;

	logic                       clk;
	logic                       rst;
	logic                       instr_valid;
	logic [31:0]                instr;
	logic                       instr_ready;
	logic                       wb_valid;
	logic [vi_pkg::RADDR_W-1:0] wb_addr;
	logic [vi_pkg::XLEN-1:0]    wb_data;

	logic [31:0]                rng_state;
	logic [vi_pkg::XLEN-1:0]    model_regs [vi_pkg::NREGS];
	logic [vi_pkg::RADDR_W-1:0] exp_addr_q [$];
	logic [vi_pkg::XLEN-1:0]    exp_data_q [$];
	int                         mismatch_count;
	int                         missing_count;
	int                         unexpected_count;

	vi_clk_gen clk_gen (
		.clk_o (clk),
		.rst_o (rst)
	);

	vi_core DUT (
		.clk_i         (clk),
		.rst_i         (rst),
		.instr_valid_i (instr_valid),
		.instr_i       (instr),
		.instr_ready_o (instr_ready),
		.wb_valid_o    (wb_valid),
		.wb_addr_o     (wb_addr),
		.wb_data_o     (wb_data)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Registers limited to r0..r7 so that hazards are dense
	function automatic logic [31:0] build_instr(input logic [31:0] op_draw,
		input logic [31:0] field_draw);
		logic [3:0] opc;
		int         pick;
		pick = int'(op_draw[31:24]) % 100;
		if (pick < 30) begin
			opc = vi_pkg::OP_MUL;
		end else if (pick < 45) begin
			opc = vi_pkg::OP_LI;
		end else if (pick < 50) begin
			opc = vi_pkg::OP_NOP;
		end else begin
			opc = 4'(int'(vi_pkg::OP_ADD) + int'(op_draw[23:16]) % 7);
		end
		if (opc == vi_pkg::OP_LI) begin
			return {opc, 2'b00, field_draw[31:29], 7'b0, field_draw[22:7]};
		end
		return {opc, 2'b00, field_draw[31:29], 2'b00, field_draw[28:26],
			2'b00, field_draw[25:23], 13'b0};
	endfunction

	task automatic model_exec(input logic [31:0] w);
		logic [3:0]                 opc;
		logic [vi_pkg::RADDR_W-1:0] rd;
		logic [vi_pkg::XLEN-1:0]    a;
		logic [vi_pkg::XLEN-1:0]    b;
		logic [vi_pkg::XLEN-1:0]    res;
		logic                       writes;
		opc = w[31:28];
		rd = w[27:23];
		a = model_regs[w[22:18]];
		b = model_regs[w[17:13]];
		writes = 1'b1;
		case (opc)
			vi_pkg::OP_ADD: res = a + b;
			vi_pkg::OP_SUB: res = a - b;
			vi_pkg::OP_AND: res = a & b;
			vi_pkg::OP_OR:  res = a | b;
			vi_pkg::OP_XOR: res = a ^ b;
			vi_pkg::OP_SLL: res = a << b[4:0];
			vi_pkg::OP_SRL: res = a >> b[4:0];
			vi_pkg::OP_LI:  res = {16'b0, w[15:0]};
			vi_pkg::OP_MUL: res = a * b;
			default: begin
				res = '0;
				writes = 1'b0;
			end
		endcase
		if (writes && rd != '0) begin
			model_regs[rd] = res;
			exp_addr_q.push_back(rd);
			exp_data_q.push_back(res);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			mismatch_count++;
		end
	endtask

	// Results are compared in program order
	always @(posedge clk) begin
		if (!rst) begin
			if (wb_valid) begin
				if (exp_addr_q.size() == 0) begin
					$display("Result for r%0d at %0t ns has no matching instruction",
						wb_addr, $time);
					unexpected_count++;
				end else begin
					check_value("result address", 32'(wb_addr), 32'(exp_addr_q.pop_front()));
					check_value("result data", wb_data, exp_data_q.pop_front());
				end
			end
			if (instr_valid && instr_ready) begin
				model_exec(instr);
			end
		end
	end

	initial begin
		int          issued;
		int          presented;
		logic        sent;
		logic [31:0] op_draw;
		instr_valid = 1'b0;
		instr = '0;
		rng_state = 32'h76b2;
		mismatch_count = 0;
		missing_count = 0;
		unexpected_count = 0;
		issued = 0;
		presented = 0;
		for (int i = 0; i < vi_pkg::NREGS; i++) begin
			model_regs[i] = '0;
		end
		@(negedge rst);
		while (issued < N_INSTR) begin
			@(posedge clk);
			sent = instr_valid && instr_ready;
			if (sent) begin
				issued++;
			end
			if (!instr_valid || sent) begin
				rng_state = lcg_step(rng_state);
				// About one cycle in four stays idle
				if (presented < N_INSTR && rng_state[31:30] != 2'b00) begin
					rng_state = lcg_step(rng_state);
					op_draw = rng_state;
					rng_state = lcg_step(rng_state);
					instr <= build_instr(op_draw, rng_state);
					instr_valid <= 1'b1;
					presented++;
				end else begin
					instr_valid <= 1'b0;
				end
			end
		end
		for (int i = 0; i < DRAIN_CYCLES && exp_addr_q.size() != 0; i++) begin
			@(posedge clk);
		end
		repeat (SETTLE_CYCLES) @(posedge clk);
		@(negedge clk);
		missing_count = exp_addr_q.size();
		if (missing_count != 0) begin
			$display("%0d expected results were never reported", missing_count);
		end
		$display("Errors: %0d mismatched, %0d missing, %0d unexpected",
			mismatch_count, missing_count, unexpected_count);
		if (mismatch_count + missing_count + unexpected_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + N_INSTR * CYCLES_PER_INSTR) @(posedge clk);
		$display("The run timed out before all instructions were issued and reported");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
src/vi_pkg.sv
src/vi_fwd_if.sv
src/vi_int_registers.sv
src/vi_decoder.sv
src/vi_bypass_ctrl.sv
src/vi_execute.sv
src/vi_writeback.sv
src/vi_core.sv
dv/vi_clk_gen.sv
dv/vi_core_assertions.sv
dv/vi_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

if ! verilator --binary --timing --assert -j 0 -f project.f --top-module vi_core_tb \
	-o vi_core_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vi_core_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$log_file"; then
	exit 0
fi
echo "Pass message not found in $log_file"
exit 1
